/* project.f */
hdl/mem_system_pkg.sv
hdl/cache_way.sv
hdl/banked_mem.sv
hdl/way_select.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
verif/tb_clock.sv
verif/mem_system_properties.sv
verif/mem_system_tb.sv

/* verif/mem_system_tb.sv */
// testbench top for the data cache, runs directed and random requests against a cache model
`timescale 1ns/1ns

module mem_system_tb;

    localparam int mem_latency = 4;
    localparam int n_random = 200;
    localparam int n_requests = 13 + n_random;
    localparam int watchdog_cycles = n_requests * (12 * mem_latency + 20);
    // three tags sharing index 5
    localparam logic [15:0] addr_a = {5'd1, 8'h05, 2'd2, 1'b0};
    localparam logic [15:0] addr_b = {5'd2, 8'h05, 2'd1, 1'b0};
    localparam logic [15:0] addr_c = {5'd3, 8'h05, 2'd3, 1'b0};

    logic clk;
    logic rst_n;
    logic rd;
    logic wr;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic done;
    logic stall;
    logic cache_hit;
    logic err;

    logic [31:0] lfsr_state;
    int checks;
    int errors;
    int test_errors;
    int test_requests;

    // reference model of both ways and the backing memory
    logic [4:0] m_tag [2][256];
    logic m_valid [2][256];
    logic m_dirty [2][256];
    logic [15:0] m_line [2][256][4];
    logic [15:0] m_mem [32768];
    logic m_victim;

    tb_clock u_tb_clock (.clk(clk));

    mem_system #(
        .MEM_LATENCY (mem_latency)
    ) u_mem_system (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit),
        .err       (err)
    );

    bind mem_system mem_system_properties u_properties (
        .clk(clk), .rst_n(rst_n), .rd(rd), .wr(wr),
        .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 256; i++) begin
            for (int k = 0; k < 2; k++) begin
                m_valid[k][i] = 1'b0;
                m_dirty[k][i] = 1'b0;
            end
        end
        for (int w = 0; w < 32768; w++) begin
            m_mem[w] = 16'(w);
        end
        m_victim = 1'b0;
    endtask

    task automatic model_access(input logic r, input logic w, input logic [15:0] a,
                                input logic [15:0] d, output logic exp_err,
                                output logic exp_hit, output logic [15:0] exp_data);
        logic [4:0] tag;
        logic [7:0] idx;
        logic [1:0] wd;
        int way;
        tag = a[15:11];
        idx = a[10:3];
        wd = a[2:1];
        exp_err = (r && w) || a[0];
        exp_hit = 1'b0;
        exp_data = '0;
        if (!exp_err) begin
            way = -1;
            for (int k = 0; k < 2; k++) begin
                if (m_valid[k][idx] && m_tag[k][idx] == tag) begin
                    way = k;
                end
            end
            exp_hit = (way >= 0);
            if (!exp_hit) begin
                if (!m_valid[0][idx]) begin
                    way = 0;
                end else if (!m_valid[1][idx]) begin
                    way = 1;
                end else begin
                    way = int'(m_victim);
                end
                // dirty victim goes back to memory before the fill
                for (int k = 0; k < 4; k++) begin
                    if (m_valid[way][idx] && m_dirty[way][idx]) begin
                        m_mem[{m_tag[way][idx], idx, 2'(k)}] = m_line[way][idx][k];
                    end
                end
                for (int k = 0; k < 4; k++) begin
                    m_line[way][idx][k] = m_mem[{tag, idx, 2'(k)}];
                end
                m_tag[way][idx] = tag;
                m_valid[way][idx] = 1'b1;
                m_dirty[way][idx] = 1'b0;
            end
            exp_data = m_line[way][idx][wd];
            if (w) begin
                m_line[way][idx][wd] = d;
                m_dirty[way][idx] = 1'b1;
            end
            m_victim = ~m_victim;
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_request(input logic r, input logic w, input logic [15:0] a,
                               input logic [15:0] d);
        logic exp_err;
        logic exp_hit;
        logic [15:0] exp_data;
        int lat;
        model_access(r, w, a, d, exp_err, exp_hit, exp_data);
        while (stall) begin
            @(posedge clk);
            #1;
        end
        rd = r;
        wr = w;
        addr = a;
        data_in = d;
        @(posedge clk);
        #1;
        rd = 1'b0;
        wr = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!done) begin
            lat++;
            @(negedge clk);
        end
        checks += 2;
        assert (err === exp_err) else begin
            errors++;
            $display("error: err = %h, expected %h (addr %h)", err, exp_err, a);
        end
        assert (cache_hit === exp_hit) else begin
            errors++;
            $display("error: cache_hit = %h, expected %h (addr %h)", cache_hit, exp_hit, a);
        end
        if (r && !w && !exp_err) begin
            checks++;
            assert (data_out === exp_data) else begin
                errors++;
                $display("error: data_out = %h, expected %h (addr %h)", data_out, exp_data, a);
            end
        end
        if (exp_hit) begin
            checks++;
            assert (lat == 1) else begin
                errors++;
                $display("hit on address %h took %0d cycles instead of one", a, lat);
            end
        end
        test_requests++;
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d requests, %0d errors", num, name, test_requests,
                 errors - test_errors);
        test_errors = errors;
        test_requests = 0;
    endtask

    initial begin : stimulus
        logic [15:0] tag_r;
        logic [15:0] idx_r;
        logic [15:0] word_r;
        logic [15:0] op_r;
        logic [15:0] ra;
        rst_n = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        data_in = '0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        test_requests = 0;
        lfsr_state = 32'h86e7;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_request(1'b1, 1'b0, addr_a, '0);
        run_request(1'b1, 1'b0, addr_a, '0);
        report_test(1, "cold read then hit");

        run_request(1'b0, 1'b1, addr_a, 16'hbeef);
        run_request(1'b1, 1'b0, addr_a, '0);
        report_test(2, "write hit");

        run_request(1'b0, 1'b1, addr_b, 16'h1234);
        run_request(1'b1, 1'b0, addr_c, '0);
        run_request(1'b1, 1'b0, addr_a, '0);
        run_request(1'b1, 1'b0, addr_b, '0);
        report_test(3, "eviction and write-back");

        // eight tags over indexes 0x40 and 0x41
        for (int i = 0; i < n_random; i++) begin
            tag_r = random_bits(3);
            idx_r = random_bits(1);
            word_r = random_bits(2);
            op_r = random_bits(1);
            ra = {tag_r[4:0], 7'b0100000, idx_r[0], word_r[1:0], 1'b0};
            run_request(!op_r[0], op_r[0], ra, random_bits(16));
        end
        report_test(4, "random reads and writes");

        run_request(1'b1, 1'b0, addr_a | 16'h1, '0);
        run_request(1'b1, 1'b1, addr_b, 16'h5555);
        run_request(1'b0, 1'b1, addr_c | 16'h1, 16'hdead);
        run_request(1'b1, 1'b0, addr_a, '0);
        run_request(1'b1, 1'b0, addr_b, '0);
        report_test(5, "refused requests");

        if (u_mem_system.u_properties.failures != 0) begin
            $display("%0d protocol assertions failed", u_mem_system.u_properties.failures);
            errors += u_mem_system.u_properties.failures;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, requests still running after %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verif/mem_system_properties.sv */
// protocol assertions for the cache top level, bound into mem_system by the testbench
`timescale 1ns/1ns

module mem_system_properties (
    input logic clk,
    input logic rst_n,
    input logic rd,
    input logic wr,
    input logic done,
    input logic stall,
    input logic cache_hit,
    input logic err
);

    // read back by the testbench at the end of the run
    int failures = 0;

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            failures++;
            $error("done stayed high for more than one cycle");
        end

    stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
        else begin
            failures++;
            $error("stall high right after reset");
        end

    // a hit finishes in the compare cycle right after the request
    hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        done && cache_hit |-> $past(rd || wr) && !$past(stall))
        else begin
            failures++;
            $error("cache_hit not one cycle after an accepted request");
        end

    stall_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (rd || wr) && !stall |=> stall)
        else begin
            failures++;
            $error("stall did not rise after a request");
        end

    // a refused request ends in the cycle right after it was taken
    err_timing: assert property (@(posedge clk) disable iff (!rst_n)
        err |-> $past(rd || wr) && !$past(stall))
        else begin
            failures++;
            $error("err not one cycle after an accepted request");
        end

endmodule

/* verif/tb_clock.sv */
// free-running 4 ns clock for the cache testbench, instantiated once by the testbench top
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

/* hdl/mem_system.sv */
// top level of the two-way data cache with its banked backing memory
`timescale 1ns/1ns

module mem_system #(
    parameter int MEM_LATENCY = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd,
    input  logic        wr,
    input  logic [15:0] addr,
    input  logic [15:0] data_in,
    output logic [15:0] data_out,
    output logic        done,
    output logic        stall,
    output logic        cache_hit,
    output logic        err
);

    mem_system_pkg::way_cmd_t way_cmd;
    mem_system_pkg::way_status_t status0;
    mem_system_pkg::way_status_t status1;
    mem_system_pkg::way_status_t sel_status;
    mem_system_pkg::mem_cmd_t mem_cmd;
    logic en0;
    logic en1;
    logic latch_victim;
    logic bank_busy;
    logic [15:0] rd_data;
    logic rd_valid;

    cache_ctrl u_cache_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .data_in      (data_in),
        .sel_status   (sel_status),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .bank_busy    (bank_busy),
        .cmd          (way_cmd),
        .mem_cmd      (mem_cmd),
        .latch_victim (latch_victim),
        .data_out     (data_out),
        .done         (done),
        .stall        (stall),
        .cache_hit    (cache_hit),
        .err          (err)
    );

    cache_way u_way0 (.clk(clk), .rst_n(rst_n), .enable(en0), .cmd(way_cmd), .status(status0));
    cache_way u_way1 (.clk(clk), .rst_n(rst_n), .enable(en1), .cmd(way_cmd), .status(status1));

    // refused requests leave the victim bit alone
    way_select u_way_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .latch_victim (latch_victim),
        .done         (done & ~err),
        .status0      (status0),
        .status1      (status1),
        .en0          (en0),
        .en1          (en1),
        .sel_way      (),
        .sel_status   (sel_status)
    );

    banked_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_banked_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_cmd   (mem_cmd),
        .bank_busy (bank_busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

/* hdl/cache_ctrl.sv */
// request FSM of the data cache, runs compare, write-back, line fill and replay for each request
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd,
    input  logic                        wr,
    input  logic [15:0]                 addr,
    input  logic [15:0]                 data_in,
    input  mem_system_pkg::way_status_t sel_status,
    input  logic [15:0]                 rd_data,
    input  logic                        rd_valid,
    input  logic                        bank_busy,
    output mem_system_pkg::way_cmd_t    cmd,
    output mem_system_pkg::mem_cmd_t    mem_cmd,
    output logic                        latch_victim,
    output logic [15:0]                 data_out,
    output logic                        done,
    output logic                        stall,
    output logic                        cache_hit,
    output logic                        err
);

    localparam logic [1:0] last_word = 2'(mem_system_pkg::words_per_line - 1);

    mem_system_pkg::ctrl_state_e state;
    mem_system_pkg::ctrl_state_e next_state;
    mem_system_pkg::addr_fields_t req_addr;
    logic [15:0] req_data;
    logic req_wr;
    logic [1:0] wb_cnt;
    logic [1:0] issue_cnt;
    logic [1:0] ret_cnt;
    logic mem_accept;
    logic bad_req;

    assign bad_req = (rd && wr) || ((rd || wr) && addr[0]);
    assign mem_accept = (mem_cmd.op != mem_system_pkg::mem_idle) && !bank_busy;

    always_comb begin
        next_state = state;
        case (state)
            mem_system_pkg::st_idle: begin
                if (bad_req) begin
                    next_state = mem_system_pkg::st_error;
                end else if (rd || wr) begin
                    next_state = mem_system_pkg::st_compare;
                end
            end
            mem_system_pkg::st_compare: begin
                if (sel_status.hit) begin
                    next_state = mem_system_pkg::st_idle;
                end else if (sel_status.valid && sel_status.dirty) begin
                    next_state = mem_system_pkg::st_writeback;
                end else begin
                    next_state = mem_system_pkg::st_fill_req;
                end
            end
            mem_system_pkg::st_writeback: begin
                if (mem_accept && wb_cnt == last_word) begin
                    next_state = mem_system_pkg::st_fill_req;
                end
            end
            mem_system_pkg::st_fill_req: begin
                if (mem_accept && issue_cnt == last_word) begin
                    next_state = mem_system_pkg::st_fill_wait;
                end
            end
            mem_system_pkg::st_fill_wait: begin
                if (rd_valid && ret_cnt == last_word) begin
                    next_state = mem_system_pkg::st_replay;
                end
            end
            default: next_state = mem_system_pkg::st_idle;
        endcase
    end

    // word counters wrap back to zero after a full line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_system_pkg::st_idle;
            wb_cnt <= '0;
            issue_cnt <= '0;
            ret_cnt <= '0;
            req_wr <= 1'b0;
        end else begin
            state <= next_state;
            if (state == mem_system_pkg::st_writeback && mem_accept) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
            if (state == mem_system_pkg::st_fill_req && mem_accept) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (rd_valid) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
            if (state == mem_system_pkg::st_idle && (rd || wr)) begin
                req_wr <= wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_system_pkg::st_idle && (rd || wr)) begin
            req_addr <= addr;
            req_data <= data_in;
        end
    end

    // way command, compare access unless a miss is being serviced
    always_comb begin
        cmd.index = req_addr.index;
        cmd.tag = req_addr.tag;
        cmd.word = req_addr.word;
        cmd.wdata = req_data;
        cmd.comp = 1'b1;
        cmd.write = 1'b0;
        cmd.set_dirty = 1'b0;
        case (state)
            mem_system_pkg::st_compare, mem_system_pkg::st_replay: begin
                cmd.write = req_wr;
                cmd.set_dirty = req_wr;
            end
            mem_system_pkg::st_writeback: begin
                cmd.comp = 1'b0;
                cmd.word = wb_cnt;
            end
            mem_system_pkg::st_fill_req, mem_system_pkg::st_fill_wait: begin
                cmd.comp = 1'b0;
                cmd.word = ret_cnt;
                cmd.wdata = rd_data;
                cmd.write = rd_valid;
            end
            default: ;
        endcase
    end

    // held unchanged by construction while bank_busy is high
    always_comb begin
        mem_cmd.op = mem_system_pkg::mem_idle;
        mem_cmd.addr = '0;
        mem_cmd.wdata = sel_status.rdata;
        if (state == mem_system_pkg::st_writeback) begin
            mem_cmd.op = mem_system_pkg::mem_write;
            mem_cmd.addr = {sel_status.tag, req_addr.index, wb_cnt, 1'b0};
        end else if (state == mem_system_pkg::st_fill_req) begin
            mem_cmd.op = mem_system_pkg::mem_read;
            mem_cmd.addr = {req_addr.tag, req_addr.index, issue_cnt, 1'b0};
        end
    end

    assign latch_victim = (state == mem_system_pkg::st_compare) && !sel_status.hit;
    assign cache_hit = (state == mem_system_pkg::st_compare) && sel_status.hit;
    assign err = (state == mem_system_pkg::st_error);
    assign done = cache_hit || err || (state == mem_system_pkg::st_replay);
    assign stall = (state != mem_system_pkg::st_idle);
    assign data_out = sel_status.rdata;

endmodule

/* hdl/way_select.sv */
// picks the hit or victim way, holds that choice through a miss and owns the global victim bit
`timescale 1ns/1ns

module way_select (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        latch_victim,
    input  logic                        done,
    input  mem_system_pkg::way_status_t status0,
    input  mem_system_pkg::way_status_t status1,
    output logic                        en0,
    output logic                        en1,
    output logic                        sel_way,
    output mem_system_pkg::way_status_t sel_status
);

    logic victim_bit;
    logic hold;
    logic held_way;
    mem_system_pkg::way_status_t held_status;
    mem_system_pkg::way_status_t live_status;
    logic victim_way;

    // invalid way first, way 0 when both are empty
    always_comb begin
        if (!status0.valid) begin
            victim_way = 1'b0;
        end else if (!status1.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = victim_bit;
        end
    end

    assign sel_way = hold ? held_way :
                     (status0.hit || status1.hit) ? status1.hit : victim_way;
    assign live_status = sel_way ? status1 : status0;

    // tag and state bits stay frozen for the write-back address
    always_comb begin
        sel_status = live_status;
        if (hold) begin
            sel_status.valid = held_status.valid;
            sel_status.dirty = held_status.dirty;
            sel_status.tag = held_status.tag;
        end
    end

    assign en0 = !hold || !sel_way;
    assign en1 = !hold || sel_way;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_bit <= 1'b0;
            hold <= 1'b0;
            held_way <= 1'b0;
        end else begin
            if (done) begin
                victim_bit <= ~victim_bit;
                hold <= 1'b0;
            end else if (latch_victim) begin
                hold <= 1'b1;
                held_way <= sel_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch_victim && !hold) begin
            held_status <= live_status;
        end
    end

endmodule

/* hdl/banked_mem.sv */
// four-bank pipelined word memory behind the cache, one access per bank every MEM_LATENCY cycles
`timescale 1ns/1ns

module banked_mem #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_system_pkg::mem_cmd_t mem_cmd,
    output logic                     bank_busy,
    output logic [mem_system_pkg::word_w-1:0] rd_data,
    output logic                     rd_valid
);

    localparam int banks = mem_system_pkg::words_per_line;
    localparam int waddr_w = mem_system_pkg::word_w - 1;
    localparam int mem_words = 1 << waddr_w;
    localparam int cnt_w = $clog2(MEM_LATENCY);

    logic [mem_system_pkg::word_w-1:0] mem_array [mem_words];
    logic [cnt_w-1:0] busy_cnt [banks];
    logic [MEM_LATENCY-1:0] pipe_valid;
    logic [mem_system_pkg::word_w-1:0] pipe_data [MEM_LATENCY];

    logic [waddr_w-1:0] word_addr;
    logic [1:0] bank;
    logic accept;

    // word w holds w at power up
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = mem_system_pkg::word_w'(i);
        end
    end

    assign word_addr = mem_cmd.addr[mem_system_pkg::word_w-1:1];
    assign bank = word_addr[1:0];
    assign bank_busy = (mem_cmd.op != mem_system_pkg::mem_idle) && (busy_cnt[bank] != '0);
    assign accept = (mem_cmd.op != mem_system_pkg::mem_idle) && !bank_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < banks; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < banks; b++) begin
                if (accept && bank == 2'(b)) begin
                    busy_cnt[b] <= cnt_w'(MEM_LATENCY - 1);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (accept && mem_cmd.op == mem_system_pkg::mem_write) begin
            mem_array[word_addr] <= mem_cmd.wdata;
        end
    end

    // read pipeline, depth MEM_LATENCY, keeps issue order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[MEM_LATENCY-2:0],
                           accept && (mem_cmd.op == mem_system_pkg::mem_read)};
        end
    end

    always_ff @(posedge clk) begin
        pipe_data[0] <= mem_array[word_addr];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign rd_data = pipe_data[MEM_LATENCY-1];
    assign rd_valid = pipe_valid[MEM_LATENCY-1];

endmodule

/* hdl/cache_way.sv */
// one cache way, instantiated twice by the top level and driven by the shared way command
`timescale 1ns/1ns

module cache_way (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        enable,
    input  mem_system_pkg::way_cmd_t    cmd,
    output mem_system_pkg::way_status_t status
);

    localparam int sets = 1 << mem_system_pkg::index_w;

    logic [sets-1:0] valid_q;
    logic [sets-1:0] dirty_q;
    logic [mem_system_pkg::tag_w-1:0] tag_mem [sets];
    logic [mem_system_pkg::word_w-1:0] data_mem [sets][mem_system_pkg::words_per_line];

    logic tag_hit;
    logic fill_write;
    logic do_write;

    // lookup is purely combinational on the command fields
    assign tag_hit = valid_q[cmd.index] && (tag_mem[cmd.index] == cmd.tag);

    always_comb begin
        status.hit = tag_hit;
        status.valid = valid_q[cmd.index];
        status.dirty = dirty_q[cmd.index];
        status.tag = tag_mem[cmd.index];
        status.rdata = data_mem[cmd.index][cmd.word];
    end

    // fill writes unconditionally, compare writes only on a hit
    assign fill_write = enable && cmd.write && !cmd.comp;
    assign do_write = fill_write || (enable && cmd.write && cmd.comp && tag_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_write) begin
            valid_q[cmd.index] <= 1'b1;
            dirty_q[cmd.index] <= 1'b0;
        end else if (do_write && cmd.set_dirty) begin
            dirty_q[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            data_mem[cmd.index][cmd.word] <= cmd.wdata;
        end
        // tag is rewritten on every fill word, same value each time
        if (fill_write) begin
            tag_mem[cmd.index] <= cmd.tag;
        end
    end

endmodule

/* hdl/mem_system_pkg.sv */
// shared widths, address split, way and memory command structs and the FSM and opcode enums
package mem_system_pkg;

    localparam int tag_w = 5;
    localparam int index_w = 8;
    localparam int word_w = 16;
    localparam int words_per_line = 4;

    // byte address as seen by the cache
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
        logic [1:0]         word;
        logic               byte_sel;
    } addr_fields_t;

    // one command, shared by both ways
    typedef struct packed {
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
        logic [1:0]         word;
        logic [word_w-1:0]  wdata;
        logic               comp;
        logic               write;
        logic               set_dirty;
    } way_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [tag_w-1:0]  tag;
        logic [word_w-1:0] rdata;
    } way_status_t;

    typedef enum logic [1:0] {
        mem_idle,
        mem_read,
        mem_write
    } mem_op_e;

    typedef struct packed {
        mem_op_e           op;
        logic [word_w-1:0] addr;
        logic [word_w-1:0] wdata;
    } mem_cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill_req,
        st_fill_wait,
        st_replay,
        st_error
    } ctrl_state_e;

endpackage
